// ==== src.f ====
+incdir+common
common/thumb_decode_pkg.sv
design/alu_op_decoder.sv
design/mem_op_decoder.sv
reg_list/reg_list_picker.sv
reg_list/reg_list_sequencer.sv
design/thumb_decode_ctrl.sv
testbench/tb_clock_gen.sv
testbench/tb_thumb_decode.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the testbench with Verilator, then judges the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f src.f --top-module tb_thumb_decode > sim.log 2>&1 &&
    ./obj_dir/Vtb_thumb_decode >> sim.log 2>&1
grep -q "Some tests failed" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "All tests passed" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation finished cleanly"
exit 0

// ==== testbench/tb_thumb_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "thumb_decode_defines.svh"

module tb_thumb_decode;

    import thumb_decode_pkg::*;

    localparam int SINGLE_PER_GROUP = 150;
    localparam int MULTI_PER_KIND   = 30;
    localparam int MAX_MULTI_CYCLES = 10;
    localparam int UNSUP_TESTS      = 40;
    localparam int WB               = `THUMB_WORD_BYTES;
    // twice the summed length of all tests, with room for reset and the restart
    localparam int TIMEOUT_CYCLES   = 2 * (2 * SINGLE_PER_GROUP
                                      + 4 * MULTI_PER_KIND * MAX_MULTI_CYCLES
                                      + UNSUP_TESTS + 40);

    typedef struct packed {
        logic       stall;
        ctrl_word_t ctrl;
        seq_out_t   seq;
    } expect_t;

    logic        clk;
    logic        gen_reset;
    logic        tb_reset;
    logic        reset;
    logic [15:0] instr;
    ctrl_word_t  ctrl;
    seq_out_t    seq;
    logic        stall;

    logic [31:0] lfsr_state;
    string       test_name;
    int          cur_step;
    logic        check_en;
    logic        reset_check;
    int          cycles = 0;
    expect_t     exp_res;

    tb_clock_gen u_clk_gen (
        .clk_o   (clk),
        .reset_o (gen_reset)
    );

    assign reset = gen_reset | tb_reset;

    thumb_decode_ctrl DUT (
        .clk_i   (clk),
        .reset_i (reset),
        .instr_i (instr),
        .ctrl_o  (ctrl),
        .seq_o   (seq),
        .stall_o (stall)
    );

    function automatic instr_class_e classify(input logic [15:0] ins);
        casez (ins[15:9])
            7'b00?????:              return SHIFT_IMM;
            7'b010000?:              return DATA_PROC;
            7'b0101???:              return LDST_REG;
            7'b011????, 7'b100????:  return LDST_IMM;
            7'b1011010:              return PUSH;
            7'b1011110:              return POP;
            7'b11000??:              return STM;
            7'b11001??:              return LDM;
            default:                 return UNSUPPORTED;
        endcase
    endfunction

    function automatic logic [15:0] list_of(input logic [15:0] ins, input instr_class_e cls);
        logic [15:0] l;
        l = {8'h00, ins[7:0]};
        // LR rides on bit 14 for PUSH, PC on bit 15 for POP
        if (cls == PUSH && ins[8]) l[14] = 1'b1;
        if (cls == POP && ins[8]) l[15] = 1'b1;
        return l;
    endfunction

    function automatic int popcount16(input logic [15:0] l);
        int n;
        n = 0;
        for (int i = 0; i < 16; i++) begin
            if (l[i]) n++;
        end
        return n;
    endfunction

    // n-th register of the list, counted from the bottom or the top
    function automatic logic [3:0] nth_reg(input logic [15:0] l, input int n, input logic desc);
        int seen;
        int idx;
        logic [3:0] r;
        seen = 0;
        r = 4'd0;
        for (int i = 0; i < 16; i++) begin
            idx = desc ? 15 - i : i;
            if (l[idx]) begin
                if (seen == n) r = 4'(idx);
                seen++;
            end
        end
        return r;
    endfunction

    function automatic expect_t ref_result(input logic [15:0] ins, input int s);
        expect_t      r;
        instr_class_e cls;
        logic [15:0]  l;
        int           k;
        logic         load;
        r = '0;
        cls = classify(ins);
        l = list_of(ins, cls);
        k = popcount16(l);
        case (cls)
            SHIFT_IMM: begin
                r.ctrl.valid = 1'b1;
                r.ctrl.update_flags = 1'b1;
                r.ctrl.reg_write = 1'b1;
                r.ctrl.alu_b_src = SRC_IMM;
                case (ins[13:11])
                    3'b000: r.ctrl.alu_op = ALU_LSL;
                    3'b001: r.ctrl.alu_op = ALU_LSR;
                    3'b010: r.ctrl.alu_op = ALU_ASR;
                    3'b011: begin
                        r.ctrl.alu_op = ins[9] ? ALU_SUB : ALU_ADD;
                        r.ctrl.alu_b_src = ins[10] ? SRC_IMM : SRC_REG;
                    end
                    3'b100: begin
                        r.ctrl.alu_op = ALU_ADD;
                        r.ctrl.alu_a_src = SRC_ZERO;
                    end
                    3'b101: begin
                        r.ctrl.alu_op = ALU_SUB;
                        r.ctrl.reg_write = 1'b0;
                    end
                    3'b110: r.ctrl.alu_op = ALU_ADD;
                    default: r.ctrl.alu_op = ALU_SUB;
                endcase
            end
            DATA_PROC: begin
                r.ctrl.valid = 1'b1;
                r.ctrl.update_flags = 1'b1;
                r.ctrl.reg_write = 1'b1;
                // AND EOR LSL LSR ASR ADC SBC ROR TST NEG CMP CMN ORR MUL BIC MVN
                case (ins[9:6])
                    4'h0: r.ctrl.alu_op = ALU_AND;
                    4'h1: r.ctrl.alu_op = ALU_XOR;
                    4'h2: r.ctrl.alu_op = ALU_LSL;
                    4'h3: r.ctrl.alu_op = ALU_LSR;
                    4'h4: r.ctrl.alu_op = ALU_ASR;
                    4'h5: r.ctrl.alu_op = ALU_ADC;
                    4'h6: r.ctrl.alu_op = ALU_SBC;
                    4'h7: r.ctrl.alu_op = ALU_ROR;
                    4'h8: r.ctrl.alu_op = ALU_AND;
                    4'h9: r.ctrl.alu_op = ALU_SUB;
                    4'hA: r.ctrl.alu_op = ALU_SUB;
                    4'hB: r.ctrl.alu_op = ALU_ADD;
                    4'hC: r.ctrl.alu_op = ALU_OR;
                    4'hD: r.ctrl.alu_op = ALU_MUL;
                    4'hE: r.ctrl.alu_op = ALU_BIC;
                    default: r.ctrl.alu_op = ALU_NOT;
                endcase
                if (ins[9:6] == 4'h8 || ins[9:6] == 4'hA || ins[9:6] == 4'hB)
                    r.ctrl.reg_write = 1'b0;
                if (ins[9:6] == 4'h9)
                    r.ctrl.alu_a_src = SRC_ZERO;
            end
            LDST_REG, LDST_IMM: begin
                r.ctrl.valid = 1'b1;
                r.ctrl.alu_op = ALU_ADD;
                load = ins[11];
                if (cls == LDST_REG) begin
                    load = ins[11] | (ins[10] & ins[9]);
                end else begin
                    r.ctrl.alu_b_src = SRC_IMM;
                end
                if (load) begin
                    r.ctrl.mem_read = 1'b1;
                    r.ctrl.reg_write = 1'b1;
                    r.ctrl.wb_src = WB_MEMORY;
                end else begin
                    r.ctrl.mem_write = 1'b1;
                    if (cls == LDST_REG) r.ctrl.store_data_sel = STORE_REG3;
                end
            end
            PUSH, POP, STM, LDM: begin
                r.ctrl.valid = 1'b1;
                r.ctrl.alu_b_src = SRC_SEQ_OFFSET;
                r.ctrl.alu_op = (cls == PUSH) ? ALU_SUB : ALU_ADD;
                if (s < k) begin
                    r.stall = 1'b1;
                    r.seq.stall = 1'b1;
                    r.seq.reg_addr = nth_reg(l, s, cls == LDM);
                    if (cls == PUSH || cls == STM) begin
                        r.ctrl.mem_write = 1'b1;
                        r.ctrl.rf_addr2_src = ADDR_SEQ;
                    end else begin
                        r.ctrl.mem_read = 1'b1;
                        r.ctrl.reg_write = 1'b1;
                        r.ctrl.wb_src = WB_MEMORY;
                        r.ctrl.dest_addr_src = ADDR_SEQ;
                    end
                    case (cls)
                        PUSH: r.seq.offset = 32'(WB * (k - s));
                        LDM:  r.seq.offset = 32'(WB * (k - 1 - s));
                        default: r.seq.offset = 32'(WB * s);
                    endcase
                end else begin
                    r.seq.offset = 32'(WB * k);
                    r.ctrl.dest_addr_src = ADDR_SEQ;
                    r.ctrl.reg_write = 1'b1;
                    if (cls == PUSH || cls == POP) begin
                        r.seq.reg_addr = 4'(`THUMB_SP_NUM);
                    end else begin
                        r.seq.reg_addr = {1'b0, ins[10:8]};
                        if (cls == LDM && l[ins[10:8]]) r.ctrl.reg_write = 1'b0;
                    end
                end
            end
            default: ;
        endcase
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // compare at the falling edge, halfway between input changes
    always @(negedge clk) begin
        if (check_en) begin
            exp_res = ref_result(instr, cur_step);
            if (reset_check) begin
                check_value({test_name, " stall in reset"}, 64'(0), 64'(stall));
                check_value({test_name, " mem_read in reset"}, 64'(0), 64'(ctrl.mem_read));
                check_value({test_name, " mem_write in reset"}, 64'(0), 64'(ctrl.mem_write));
                check_value({test_name, " reg_write in reset"}, 64'(0), 64'(ctrl.reg_write));
            end else begin
                check_value({test_name, " stall"}, 64'(exp_res.stall), 64'(stall));
                check_value({test_name, " ctrl"}, 64'(exp_res.ctrl), 64'(ctrl));
                check_value({test_name, " seq"}, 64'(exp_res.seq), 64'(seq));
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] st);
        // taps 32 22 2 1
        return {st[30:0], st[31] ^ st[21] ^ st[1] ^ st[0]};
    endfunction

    task automatic get_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // drive one instruction and hold it until the DUT drops stall
    task automatic run_instr(input string name, input logic [15:0] ins, input int exp_k);
        logic st;
        int   steps;
        test_name = name;
        instr = ins;
        cur_step = 0;
        steps = 0;
        st = 1'b1;
        while (st) begin
            @(negedge clk);
            st = stall;
            @(posedge clk);
            #1;
            if (st) begin
                steps++;
                cur_step = steps;
            end
        end
        check_value({name, " stall cycles"}, 64'(exp_k), 64'(steps));
    endtask

    task automatic make_multi(input int kind, output logic [15:0] ins);
        logic [31:0] r;
        logic [7:0]  l8;
        get_bits(11, r);
        l8 = r[7:0];
        if (l8 == 8'h00 && (kind >= 2 || !r[8])) l8 = 8'h01;
        case (kind)
            0: ins = {7'b1011010, r[8], l8};
            1: ins = {7'b1011110, r[8], l8};
            2: ins = {5'b11000, r[10:8], l8};
            default: ins = {5'b11001, r[10:8], l8};
        endcase
    endtask

    task automatic reset_mid_sequence(input string name, input logic [15:0] ins,
                                      input int exp_k);
        test_name = name;
        instr = ins;
        cur_step = 0;
        repeat (3) begin
            @(posedge clk);
            #1;
            cur_step++;
        end
        tb_reset = 1'b1;
        reset_check = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        tb_reset = 1'b0;
        reset_check = 1'b0;
        // the same instruction must start over at step 0
        run_instr({name, " restart"}, ins, exp_k);
    endtask

    initial begin
        logic [31:0]  r;
        logic [15:0]  ins;
        instr_class_e cls;
        instr = 16'h0000;
        tb_reset = 1'b0;
        check_en = 1'b0;
        reset_check = 1'b0;
        cur_step = 0;
        test_name = "idle";
        lfsr_state = 32'h342d_bfa4;

        @(negedge gen_reset);
        @(posedge clk);
        #1;
        check_en = 1'b1;

        for (int i = 0; i < SINGLE_PER_GROUP; i++) begin
            get_bits(15, r);
            ins = r[14] ? {2'b00, r[13:0]} : {6'b010000, r[9:0]};
            run_instr("alu decode", ins, 0);
        end

        for (int i = 0; i < SINGLE_PER_GROUP; i++) begin
            get_bits(15, r);
            case (r[14:13])
                2'd0: ins = {4'b0101, r[11:0]};
                2'd1: ins = {3'b011, r[12:0]};
                2'd2: ins = {4'b1000, r[11:0]};
                default: ins = {4'b1001, r[11:0]};
            endcase
            run_instr("load store", ins, 0);
        end

        for (int kind = 0; kind < 4; kind++) begin
            for (int i = 0; i < MULTI_PER_KIND; i++) begin
                make_multi(kind, ins);
                cls = classify(ins);
                run_instr("multi transfer", ins, popcount16(list_of(ins, cls)));
            end
        end

        for (int i = 0; i < UNSUP_TESTS; i++) begin
            get_bits(16, r);
            ins = r[15:0];
            if (classify(ins) == UNSUPPORTED) run_instr("unsupported", ins, 0);
        end

        // a store sequence and a load sequence, so every enable is high when reset hits
        reset_mid_sequence("reset push", {7'b1011010, 1'b0, 8'hFF}, 8);
        reset_mid_sequence("reset pop", {7'b1011110, 1'b0, 8'hFF}, 8);

        check_en = 1'b0;
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // reset stays high for the first four rising edges
    initial begin
        reset_o = 1'b1;
        repeat (4) @(posedge clk_o);
        #1 reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== design/thumb_decode_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "thumb_decode_defines.svh"

module thumb_decode_ctrl (
    input  wire logic                        clk_i,
    input  wire logic                        reset_i,
    input  wire logic [`THUMB_INSTR_W-1:0]   instr_i,
    output thumb_decode_pkg::ctrl_word_t     ctrl_o,
    output thumb_decode_pkg::seq_out_t       seq_o,
    output logic                             stall_o
);

    import thumb_decode_pkg::*;

    instr_class_e instr_class;
    ctrl_word_t   alu_ctrl;
    ctrl_word_t   mem_ctrl;
    ctrl_word_t   seq_ctrl;
    ctrl_word_t   ctrl_sel;
    seq_out_t     seq_raw;

    // classes follow the Thumb opcode map on the top seven bits
    always_comb begin
        casez (instr_i[15:9])
            7'b00?????: instr_class = SHIFT_IMM;
            7'b010000?: instr_class = DATA_PROC;
            7'b0101???: instr_class = LDST_REG;
            7'b011????,
            7'b1000???,
            7'b1001???: instr_class = LDST_IMM;
            7'b1011010: instr_class = PUSH;
            7'b1011110: instr_class = POP;
            7'b11000??: instr_class = STM;
            7'b11001??: instr_class = LDM;
            default:    instr_class = UNSUPPORTED;
        endcase
    end

    alu_op_decoder u_alu_dec (
        .instr_i (instr_i),
        .class_i (instr_class),
        .ctrl_o  (alu_ctrl)
    );

    mem_op_decoder u_mem_dec (
        .instr_i (instr_i),
        .class_i (instr_class),
        .ctrl_o  (mem_ctrl)
    );

    reg_list_sequencer u_seq (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .instr_i (instr_i),
        .class_i (instr_class),
        .seq_o   (seq_raw),
        .ctrl_o  (seq_ctrl)
    );

    always_comb begin
        case (instr_class)
            SHIFT_IMM, DATA_PROC: ctrl_sel = alu_ctrl;
            LDST_REG, LDST_IMM:   ctrl_sel = mem_ctrl;
            PUSH, POP, STM, LDM:  ctrl_sel = seq_ctrl;
            default:              ctrl_sel = CTRL_NOP;
        endcase
    end

    // sequencer state only settles at the reset edge, so hold side effects off meanwhile
    assign stall_o = seq_raw.stall & ~reset_i;

    always_comb begin
        ctrl_o = ctrl_sel;
        seq_o  = seq_raw;
        seq_o.stall = stall_o;
        if (reset_i) begin
            ctrl_o.mem_read  = 1'b0;
            ctrl_o.mem_write = 1'b0;
            ctrl_o.reg_write = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== reg_list/reg_list_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "thumb_decode_defines.svh"

module reg_list_sequencer (
    input  wire logic                        clk_i,
    input  wire logic                        reset_i,
    input  wire logic [`THUMB_INSTR_W-1:0]   instr_i,
    input  thumb_decode_pkg::instr_class_e   class_i,
    output thumb_decode_pkg::seq_out_t       seq_o,
    output thumb_decode_pkg::ctrl_word_t     ctrl_o
);

    import thumb_decode_pkg::*;

    localparam int LIST_W  = `THUMB_REG_LIST_W;
    localparam int ADDR_W  = `THUMB_REG_ADDR_W;
    localparam int WORD_W  = `THUMB_WORD_W;
    localparam int COUNT_W = $clog2(LIST_W) + 1;
    localparam logic [WORD_W-1:0] WORD_BYTES = WORD_W'(`THUMB_WORD_BYTES);
    localparam logic [ADDR_W-1:0] SP_NUM     = ADDR_W'(`THUMB_SP_NUM);

    logic [LIST_W-1:0]  reg_list;
    logic [LIST_W-1:0]  remaining_q;
    logic [COUNT_W-1:0] step_q;
    logic [ADDR_W-1:0]  pick_num;
    logic [LIST_W-1:0]  pick_mask;
    logic               any_pending;
    logic [COUNT_W-1:0] list_count;
    logic               is_multi;
    logic               stall;
    logic               base_in_list;
    logic [ADDR_W-1:0]  base_num;
    logic [WORD_W-1:0]  k_bytes;
    logic [WORD_W-1:0]  s_bytes;

    always_comb begin
        case (class_i)
            PUSH:     reg_list = {1'b0, instr_i[8], 6'b0, instr_i[7:0]};
            POP:      reg_list = {instr_i[8], 7'b0, instr_i[7:0]};
            STM, LDM: reg_list = {8'b0, instr_i[7:0]};
            default:  reg_list = '0;
        endcase
    end

    assign is_multi = (class_i == PUSH) || (class_i == POP) ||
                      (class_i == STM)  || (class_i == LDM);

    reg_list_picker u_picker (
        .list_i          (reg_list),
        .remaining_i     (remaining_q),
        .highest_first_i (class_i == LDM),
        .pick_num_o      (pick_num),
        .pick_mask_o     (pick_mask),
        .any_o           (any_pending),
        .count_o         (list_count)
    );

    // fetch holds the instruction until every listed register has moved
    assign stall = is_multi & any_pending;

    always_ff @(posedge clk_i) begin
        if (reset_i || !stall) begin
            remaining_q <= '1;
            step_q      <= '0;
        end else begin
            remaining_q <= remaining_q & ~pick_mask;
            step_q      <= step_q + 1'b1;
        end
    end

    assign base_num     = {1'b0, instr_i[10:8]};
    assign base_in_list = instr_i[instr_i[10:8]];
    assign k_bytes      = WORD_W'(list_count) * WORD_BYTES;
    assign s_bytes      = WORD_W'(step_q) * WORD_BYTES;

    always_comb begin
        seq_o  = '0;
        ctrl_o = CTRL_NOP;

        seq_o.stall = stall;
        if (is_multi) begin
            ctrl_o.valid     = 1'b1;
            ctrl_o.alu_a_src = SRC_REG;
            ctrl_o.alu_b_src = SRC_SEQ_OFFSET;
            ctrl_o.alu_op    = (class_i == PUSH) ? ALU_SUB : ALU_ADD;

            if (stall) begin
                seq_o.reg_addr = pick_num;
                case (class_i)
                    PUSH: begin
                        seq_o.offset         = k_bytes - s_bytes;
                        ctrl_o.mem_write     = 1'b1;
                        ctrl_o.rf_addr2_src  = ADDR_SEQ;
                    end
                    STM: begin
                        seq_o.offset         = s_bytes;
                        ctrl_o.mem_write     = 1'b1;
                        ctrl_o.rf_addr2_src  = ADDR_SEQ;
                    end
                    POP: begin
                        seq_o.offset         = s_bytes;
                        ctrl_o.mem_read      = 1'b1;
                        ctrl_o.reg_write     = 1'b1;
                        ctrl_o.wb_src        = WB_MEMORY;
                        ctrl_o.dest_addr_src = ADDR_SEQ;
                    end
                    default: begin
                        // LDMIA walks downward from the top word of the block
                        seq_o.offset         = k_bytes - WORD_BYTES - s_bytes;
                        ctrl_o.mem_read      = 1'b1;
                        ctrl_o.reg_write     = 1'b1;
                        ctrl_o.wb_src        = WB_MEMORY;
                        ctrl_o.dest_addr_src = ADDR_SEQ;
                    end
                endcase
            end else begin
                // last cycle writes back the updated SP or base register
                seq_o.offset         = k_bytes;
                seq_o.reg_addr       = ((class_i == PUSH) || (class_i == POP)) ? SP_NUM
                                                                               : base_num;
                ctrl_o.dest_addr_src = ADDR_SEQ;
                ctrl_o.reg_write     = !((class_i == LDM) && base_in_list);
            end
        end
    end

endmodule

`default_nettype wire

// ==== reg_list/reg_list_picker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "thumb_decode_defines.svh"

module reg_list_picker (
    input  wire logic [`THUMB_REG_LIST_W-1:0]        list_i,
    input  wire logic [`THUMB_REG_LIST_W-1:0]        remaining_i,
    input  wire logic                                highest_first_i,
    output logic [`THUMB_REG_ADDR_W-1:0]             pick_num_o,
    output logic [`THUMB_REG_LIST_W-1:0]             pick_mask_o,
    output logic                                     any_o,
    output logic [$clog2(`THUMB_REG_LIST_W):0]       count_o
);

    logic [`THUMB_REG_LIST_W-1:0] pending;
    logic [`THUMB_REG_ADDR_W-1:0] low_num;
    logic [`THUMB_REG_ADDR_W-1:0] high_num;

    assign pending = list_i & remaining_i;
    assign any_o   = |pending;

    // scanning downward leaves the lowest set bit, upward the highest
    always_comb begin
        low_num  = '0;
        high_num = '0;
        for (int i = `THUMB_REG_LIST_W - 1; i >= 0; i--) begin
            if (pending[i]) begin
                low_num = `THUMB_REG_ADDR_W'(i);
            end
        end
        for (int i = 0; i < `THUMB_REG_LIST_W; i++) begin
            if (pending[i]) begin
                high_num = `THUMB_REG_ADDR_W'(i);
            end
        end
    end

    assign pick_num_o  = highest_first_i ? high_num : low_num;
    assign pick_mask_o = any_o ? (`THUMB_REG_LIST_W'(1) << pick_num_o) : '0;

    // count covers the whole list, not only what is still pending
    always_comb begin
        count_o = '0;
        for (int i = 0; i < `THUMB_REG_LIST_W; i++) begin
            count_o = count_o + ($clog2(`THUMB_REG_LIST_W) + 1)'(list_i[i]);
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_op_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "thumb_decode_defines.svh"

module mem_op_decoder (
    input  wire logic [`THUMB_INSTR_W-1:0]   instr_i,
    input  thumb_decode_pkg::instr_class_e   class_i,
    output thumb_decode_pkg::ctrl_word_t     ctrl_o
);

    import thumb_decode_pkg::*;

    logic is_reg_load;
    logic is_imm_load;

    // register offset group also loads for the two signed forms at 10:9 = 11
    assign is_reg_load = instr_i[11] | (&instr_i[10:9]);
    assign is_imm_load = instr_i[11];

    always_comb begin
        ctrl_o = CTRL_NOP;

        case (class_i)
            LDST_REG: begin
                ctrl_o.valid  = 1'b1;
                ctrl_o.alu_op = ALU_ADD;
                if (is_reg_load) begin
                    ctrl_o.mem_read  = 1'b1;
                    ctrl_o.reg_write = 1'b1;
                    ctrl_o.wb_src    = WB_MEMORY;
                end else begin
                    // the offset register sits in the second field here
                    ctrl_o.mem_write      = 1'b1;
                    ctrl_o.store_data_sel = STORE_REG3;
                end
            end
            LDST_IMM: begin
                ctrl_o.valid     = 1'b1;
                ctrl_o.alu_op    = ALU_ADD;
                ctrl_o.alu_b_src = SRC_IMM;
                if (is_imm_load) begin
                    ctrl_o.mem_read  = 1'b1;
                    ctrl_o.reg_write = 1'b1;
                    ctrl_o.wb_src    = WB_MEMORY;
                end else begin
                    ctrl_o.mem_write = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/alu_op_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "thumb_decode_defines.svh"

module alu_op_decoder (
    input  wire logic [`THUMB_INSTR_W-1:0]   instr_i,
    input  thumb_decode_pkg::instr_class_e   class_i,
    output thumb_decode_pkg::ctrl_word_t     ctrl_o
);

    import thumb_decode_pkg::*;

    logic [4:0] shift_code;
    logic [3:0] dp_code;

    assign shift_code = instr_i[13:9];
    assign dp_code    = instr_i[9:6];

    always_comb begin
        ctrl_o = CTRL_NOP;

        case (class_i)
            SHIFT_IMM: begin
                ctrl_o.valid        = 1'b1;
                ctrl_o.update_flags = 1'b1;
                ctrl_o.reg_write    = 1'b1;
                casez (shift_code)
                    5'b000??: begin
                        ctrl_o.alu_op    = ALU_LSL;
                        ctrl_o.alu_b_src = SRC_IMM;
                    end
                    5'b001??: begin
                        ctrl_o.alu_op    = ALU_LSR;
                        ctrl_o.alu_b_src = SRC_IMM;
                    end
                    5'b010??: begin
                        ctrl_o.alu_op    = ALU_ASR;
                        ctrl_o.alu_b_src = SRC_IMM;
                    end
                    5'b01100: ctrl_o.alu_op = ALU_ADD;
                    5'b01101: ctrl_o.alu_op = ALU_SUB;
                    5'b01110, 5'b110??: begin
                        ctrl_o.alu_op    = ALU_ADD;
                        ctrl_o.alu_b_src = SRC_IMM;
                    end
                    5'b01111, 5'b111??: begin
                        ctrl_o.alu_op    = ALU_SUB;
                        ctrl_o.alu_b_src = SRC_IMM;
                    end
                    // move is an add of the immediate to zero
                    5'b100??: begin
                        ctrl_o.alu_op    = ALU_ADD;
                        ctrl_o.alu_a_src = SRC_ZERO;
                        ctrl_o.alu_b_src = SRC_IMM;
                    end
                    default: begin
                        ctrl_o.alu_op    = ALU_SUB;
                        ctrl_o.alu_b_src = SRC_IMM;
                        ctrl_o.reg_write = 1'b0;
                    end
                endcase
            end
            DATA_PROC: begin
                ctrl_o.valid        = 1'b1;
                ctrl_o.update_flags = 1'b1;
                ctrl_o.reg_write    = 1'b1;
                case (dp_code)
                    4'h0: ctrl_o.alu_op = ALU_AND;
                    4'h1: ctrl_o.alu_op = ALU_XOR;
                    4'h2: ctrl_o.alu_op = ALU_LSL;
                    4'h3: ctrl_o.alu_op = ALU_LSR;
                    4'h4: ctrl_o.alu_op = ALU_ASR;
                    4'h5: ctrl_o.alu_op = ALU_ADC;
                    4'h6: ctrl_o.alu_op = ALU_SBC;
                    4'h7: ctrl_o.alu_op = ALU_ROR;
                    4'h8: begin
                        ctrl_o.alu_op    = ALU_AND;
                        ctrl_o.reg_write = 1'b0;
                    end
                    // negate computes zero minus the operand
                    4'h9: begin
                        ctrl_o.alu_op    = ALU_SUB;
                        ctrl_o.alu_a_src = SRC_ZERO;
                    end
                    4'hA: begin
                        ctrl_o.alu_op    = ALU_SUB;
                        ctrl_o.reg_write = 1'b0;
                    end
                    4'hB: begin
                        ctrl_o.alu_op    = ALU_ADD;
                        ctrl_o.reg_write = 1'b0;
                    end
                    4'hC: ctrl_o.alu_op = ALU_OR;
                    4'hD: ctrl_o.alu_op = ALU_MUL;
                    4'hE: ctrl_o.alu_op = ALU_BIC;
                    default: ctrl_o.alu_op = ALU_NOT;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== common/thumb_decode_pkg.sv ====
`default_nettype none

`include "thumb_decode_defines.svh"

package thumb_decode_pkg;

    // instruction class, taken from the upper opcode bits
    typedef enum logic [3:0] {
        SHIFT_IMM,
        DATA_PROC,
        LDST_REG,
        LDST_IMM,
        PUSH,
        POP,
        STM,
        LDM,
        UNSUPPORTED
    } instr_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LSL,
        ALU_LSR,
        ALU_ASR,
        ALU_ROR,
        ALU_ADC,
        ALU_SBC,
        ALU_MUL,
        ALU_BIC,
        ALU_NOT
    } alu_op_e;

    // SRC_SEQ_OFFSET takes the per-step offset from the sequencer
    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM,
        SRC_ZERO,
        SRC_SEQ_OFFSET
    } alu_src_e;

    typedef enum logic {
        WB_ALU,
        WB_MEMORY
    } wb_src_e;

    typedef enum logic {
        ADDR_INSTR,
        ADDR_SEQ
    } addr_src_e;

    // picks which instruction register field feeds the store data port
    typedef enum logic {
        STORE_REG2,
        STORE_REG3
    } store_sel_e;

    typedef struct packed {
        logic       valid;
        logic       update_flags;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
        wb_src_e    wb_src;
        alu_src_e   alu_a_src;
        alu_src_e   alu_b_src;
        alu_op_e    alu_op;
        addr_src_e  rf_addr2_src;
        addr_src_e  dest_addr_src;
        store_sel_e store_data_sel;
    } ctrl_word_t;

    typedef struct packed {
        logic                           stall;
        logic [`THUMB_WORD_W-1:0]       offset;
        logic [`THUMB_REG_ADDR_W-1:0]   reg_addr;
    } seq_out_t;

    // all enables low, every select on its first choice
    localparam ctrl_word_t CTRL_NOP = '0;

endpackage

`default_nettype wire

// ==== common/thumb_decode_defines.svh ====
`ifndef THUMB_DECODE_DEFINES_SVH
`define THUMB_DECODE_DEFINES_SVH

// width of one fetched instruction
`define THUMB_INSTR_W       16

// register file has sixteen entries
`define THUMB_REG_ADDR_W    4

// one bit per register in a multi-register transfer
`define THUMB_REG_LIST_W    16

`define THUMB_WORD_W        32

// stack pointer lives in r13
`define THUMB_SP_NUM        13

// every multi-register step moves one full word
`define THUMB_WORD_BYTES    4

`endif
